// ==== rtl/tomasulo_defs.svh ====
`ifndef TOMASULO_DEFS_SVH
`define TOMASULO_DEFS_SVH

// Operand and result width.
`define DATA_W 32

// A producer tag is a reorder buffer index.
`define TAG_W 5

`define REG_COUNT 32

`define RS_ENTRIES 4

// Must stay equal to 2**TAG_W so that the head and tail pointers wrap on their own.
`define ROB_DEPTH 32

`endif

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;  // Not used by the core, shifts take the amount from rt.
        funct_e     funct;
    } r_format_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;   // Destination register of an I-type instruction.
        logic [15:0] imm;  // Sign-extended before use.
    } i_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_u;

endpackage

// ==== rtl/ooo_pkg.sv ====
`include "tomasulo_defs.svh"

package ooo_pkg;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    typedef struct packed {
        alu_op_e             op;
        logic [`TAG_W-1:0]   dest;  // Reorder buffer slot of this instruction.
        logic [`DATA_W-1:0]  val1;
        logic [`DATA_W-1:0]  val2;
        logic [`TAG_W-1:0]   tag1;  // Producer of val1 while rdy1 is low.
        logic [`TAG_W-1:0]   tag2;
        logic                rdy1;
        logic                rdy2;
    } rs_entry_t;

    typedef struct packed {
        logic               valid;
        alu_op_e            op;
        logic [`TAG_W-1:0]  dest;
        logic [`DATA_W-1:0] op1;
        logic [`DATA_W-1:0] op2;
    } dispatch_t;

    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        logic [`DATA_W-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic               valid;
        logic [4:0]         rd;
        logic [`DATA_W-1:0] value;
    } commit_t;

endpackage

// ==== rtl/issue_unit.sv ====
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module issue_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               instr_valid,
    input  isa_pkg::instr_u    instr,
    output logic               instr_ready,
    output logic               issue_write,
    output ooo_pkg::rs_entry_t issue_entry,
    input  logic               rs_full,
    output logic               alloc,
    output logic [4:0]         alloc_rd,
    input  logic [`TAG_W-1:0]  alloc_tag,
    input  logic               rob_full,
    input  ooo_pkg::cdb_t      cdb0,
    input  ooo_pkg::cdb_t      cdb1
);

    logic [`DATA_W-1:0]   value_file [`REG_COUNT];
    logic [`TAG_W-1:0]    reg_tag [`REG_COUNT];
    logic [`REG_COUNT-1:0] reg_busy;

    ooo_pkg::alu_op_e     op;
    logic [4:0]           dest;
    logic                 use_imm;
    logic [`DATA_W-1:0]   imm_ext;
    logic                 accept;
    ooo_pkg::cdb_t        src1;
    ooo_pkg::cdb_t        src2;

    // Returns the operand as ready with its value, or as waiting on its producer tag.
    function automatic ooo_pkg::cdb_t lookup(input logic [4:0] r);
        ooo_pkg::cdb_t src;
        src.valid = 1'b1;
        src.tag   = reg_tag[r];
        src.value = value_file[r];
        if (reg_busy[r]) begin
            src.valid = 1'b0;
            if (cdb0.valid && cdb0.tag == reg_tag[r]) begin
                src.valid = 1'b1;
                src.value = cdb0.value;
            end else if (cdb1.valid && cdb1.tag == reg_tag[r]) begin
                src.valid = 1'b1;
                src.value = cdb1.value;
            end
        end
        return src;
    endfunction

    assign instr_ready = !rs_full && !rob_full;
    assign accept      = instr_valid && instr_ready;
    assign imm_ext     = {{(`DATA_W-16){instr.i.imm[15]}}, instr.i.imm};

    always_comb begin
        op      = ooo_pkg::ALU_ADD;
        dest    = 5'd0;  // Unknown opcodes retire harmlessly into r0.
        use_imm = 1'b1;
        case (instr.r.opcode)
            isa_pkg::OP_RTYPE: begin
                dest    = instr.r.rd;
                use_imm = 1'b0;
                case (instr.r.funct)
                    isa_pkg::FN_SUB: op = ooo_pkg::ALU_SUB;
                    isa_pkg::FN_AND: op = ooo_pkg::ALU_AND;
                    isa_pkg::FN_OR:  op = ooo_pkg::ALU_OR;
                    isa_pkg::FN_XOR: op = ooo_pkg::ALU_XOR;
                    isa_pkg::FN_SLT: op = ooo_pkg::ALU_SLT;
                    isa_pkg::FN_SLL: op = ooo_pkg::ALU_SLL;
                    isa_pkg::FN_SRL: op = ooo_pkg::ALU_SRL;
                    default:         op = ooo_pkg::ALU_ADD;
                endcase
            end
            isa_pkg::OP_ADDI: dest = instr.i.rt;
            isa_pkg::OP_SLTI: begin
                dest = instr.i.rt;
                op   = ooo_pkg::ALU_SLT;
            end
            isa_pkg::OP_ANDI: begin
                dest = instr.i.rt;
                op   = ooo_pkg::ALU_AND;
            end
            isa_pkg::OP_ORI: begin
                dest = instr.i.rt;
                op   = ooo_pkg::ALU_OR;
            end
            isa_pkg::OP_XORI: begin
                dest = instr.i.rt;
                op   = ooo_pkg::ALU_XOR;
            end
            default: ;
        endcase
    end

    always_comb begin
        src1 = lookup(instr.r.rs);
        src2 = lookup(instr.r.rt);
        if (use_imm) begin
            src2 = '{valid: 1'b1, tag: '0, value: imm_ext};
        end
    end

    always_comb begin
        issue_entry.op   = op;
        issue_entry.dest = alloc_tag;
        issue_entry.val1 = src1.value;
        issue_entry.tag1 = src1.tag;
        issue_entry.rdy1 = src1.valid;
        issue_entry.val2 = src2.value;
        issue_entry.tag2 = src2.tag;
        issue_entry.rdy2 = src2.valid;
    end

    assign issue_write = accept;
    assign alloc       = accept;
    assign alloc_rd    = dest;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            reg_busy <= '0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                value_file[i] <= '0;
                reg_tag[i]    <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (reg_busy[i] && cdb0.valid && cdb0.tag == reg_tag[i]) begin
                    value_file[i] <= cdb0.value;
                    reg_busy[i]   <= 1'b0;
                end
                if (reg_busy[i] && cdb1.valid && cdb1.tag == reg_tag[i]) begin
                    value_file[i] <= cdb1.value;
                    reg_busy[i]   <= 1'b0;
                end
            end
            if (accept && dest != 5'd0) begin  // A new producer overrides a clear in this cycle.
                reg_busy[dest] <= 1'b1;
                reg_tag[dest]  <= alloc_tag;
            end
        end
    end

endmodule

// ==== rtl/reservation_station.sv ====
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module reservation_station (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_write,
    input  ooo_pkg::rs_entry_t issue_entry,
    output logic               full,
    input  ooo_pkg::cdb_t      cdb0,
    input  ooo_pkg::cdb_t      cdb1,
    output ooo_pkg::dispatch_t dispatch0,
    output ooo_pkg::dispatch_t dispatch1
);

    localparam int PTR_W = $clog2(`RS_ENTRIES);

    ooo_pkg::rs_entry_t     entries [`RS_ENTRIES];
    logic [`RS_ENTRIES-1:0] busy;
    logic [`RS_ENTRIES-1:0] ready;
    logic [PTR_W-1:0]       start_ptr;
    logic [PTR_W-1:0]       sel0;
    logic [PTR_W-1:0]       sel1;
    logic [PTR_W-1:0]       free_idx;
    logic                   found0;
    logic                   found1;
    logic                   found_free;

    function automatic logic tag_hit(input ooo_pkg::cdb_t bus, input logic [`TAG_W-1:0] tag);
        return bus.valid && bus.tag == tag;
    endfunction

    function automatic ooo_pkg::dispatch_t make_dispatch(input logic found,
                                                         input logic [PTR_W-1:0] idx);
        ooo_pkg::dispatch_t d;
        d.valid = found;
        d.op    = entries[idx].op;
        d.dest  = entries[idx].dest;
        d.op1   = entries[idx].val1;
        d.op2   = entries[idx].val2;
        return d;
    endfunction

    assign full = &busy;

    always_comb begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            ready[i] = busy[i] && entries[i].rdy1 && entries[i].rdy2;
        end
    end

    // Picks the first two ready entries, searching upward from the rotating start pointer.
    always_comb begin
        logic [PTR_W-1:0] idx;
        found0 = 1'b0;
        found1 = 1'b0;
        sel0   = '0;
        sel1   = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            idx = start_ptr + PTR_W'(i);  // Wraps because the entry count is a power of two.
            if (ready[idx]) begin
                if (!found0) begin
                    found0 = 1'b1;
                    sel0   = idx;
                end else if (!found1) begin
                    found1 = 1'b1;
                    sel1   = idx;
                end
            end
        end
    end

    always_comb begin
        found_free = 1'b0;
        free_idx   = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                found_free = 1'b1;
                free_idx   = PTR_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy      <= '0;
            start_ptr <= '0;
            dispatch0 <= '0;
            dispatch1 <= '0;
        end else begin
            start_ptr <= start_ptr + 1'b1;
            dispatch0 <= make_dispatch(found0, sel0);
            dispatch1 <= make_dispatch(found1, sel1);
            if (found0) begin
                busy[sel0] <= 1'b0;
            end
            if (found1) begin
                busy[sel1] <= 1'b0;
            end
            if (issue_write && found_free) begin
                busy[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `RS_ENTRIES; k++) begin
            if (busy[k] && !entries[k].rdy1) begin
                if (tag_hit(cdb0, entries[k].tag1)) begin
                    entries[k].val1 <= cdb0.value;
                    entries[k].rdy1 <= 1'b1;
                end else if (tag_hit(cdb1, entries[k].tag1)) begin
                    entries[k].val1 <= cdb1.value;
                    entries[k].rdy1 <= 1'b1;
                end
            end
            if (busy[k] && !entries[k].rdy2) begin
                if (tag_hit(cdb0, entries[k].tag2)) begin
                    entries[k].val2 <= cdb0.value;
                    entries[k].rdy2 <= 1'b1;
                end else if (tag_hit(cdb1, entries[k].tag2)) begin
                    entries[k].val2 <= cdb1.value;
                    entries[k].rdy2 <= 1'b1;
                end
            end
        end
        if (issue_write && found_free) begin
            entries[free_idx] <= issue_entry;  // Operands already carry same-cycle forwarding.
        end
    end

endmodule

// ==== rtl/exec_alu.sv ====
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module exec_alu (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t dispatch,
    output ooo_pkg::cdb_t      result
);

    logic               valid_q;
    logic [`TAG_W-1:0]  tag_q;
    logic [`DATA_W-1:0] value_q;
    logic [`DATA_W-1:0] alu_out;

    always_comb begin
        case (dispatch.op)
            ooo_pkg::ALU_SUB: alu_out = dispatch.op1 - dispatch.op2;
            ooo_pkg::ALU_AND: alu_out = dispatch.op1 & dispatch.op2;
            ooo_pkg::ALU_OR:  alu_out = dispatch.op1 | dispatch.op2;
            ooo_pkg::ALU_XOR: alu_out = dispatch.op1 ^ dispatch.op2;
            ooo_pkg::ALU_SLT: begin
                alu_out = {{(`DATA_W-1){1'b0}}, $signed(dispatch.op1) < $signed(dispatch.op2)};
            end
            ooo_pkg::ALU_SLL: alu_out = dispatch.op1 << dispatch.op2[4:0];
            ooo_pkg::ALU_SRL: alu_out = dispatch.op1 >> dispatch.op2[4:0];  // Logical shift.
            default:          alu_out = dispatch.op1 + dispatch.op2;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dispatch.valid;
        end
    end

    always_ff @(posedge clk) begin
        tag_q   <= dispatch.dest;
        value_q <= alu_out;
    end

    always_comb begin
        result.valid = valid_q;
        result.tag   = tag_q;
        result.value = value_q;
    end

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  logic [4:0]        alloc_rd,
    output logic [`TAG_W-1:0] alloc_tag,
    output logic              rob_full,
    input  ooo_pkg::cdb_t     cdb0,
    input  ooo_pkg::cdb_t     cdb1,
    output ooo_pkg::commit_t  commit
);

    localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

    logic [4:0]            rd_q [`ROB_DEPTH];
    logic [`DATA_W-1:0]    value_q [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done;
    logic [`TAG_W-1:0]     head;
    logic [`TAG_W-1:0]     tail;
    logic [CNT_W-1:0]      count;
    logic                  retire;
    logic                  do_alloc;

    assign alloc_tag = tail;
    assign rob_full  = (count == CNT_W'(`ROB_DEPTH));
    assign do_alloc  = alloc && !rob_full;
    assign retire    = (count != '0) && done[head];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done   <= '0;
            commit <= '0;
        end else begin
            commit.valid <= retire;
            commit.rd    <= rd_q[head];
            commit.value <= value_q[head];
            if (retire) begin
                head <= head + 1'b1;
            end
            if (do_alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            // Broadcast tags always name in-flight slots, never the one being allocated.
            if (cdb0.valid) begin
                done[cdb0.tag] <= 1'b1;
            end
            if (cdb1.valid) begin
                done[cdb1.tag] <= 1'b1;
            end
            case ({do_alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (cdb0.valid) begin
            value_q[cdb0.tag] <= cdb0.value;
        end
        if (cdb1.valid) begin
            value_q[cdb1.tag] <= cdb1.value;
        end
    end

endmodule

// ==== rtl/tomasulo_core.sv ====
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module tomasulo_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             instr_valid,
    input  isa_pkg::instr_u  instr,
    output logic             instr_ready,
    output ooo_pkg::commit_t commit
);

    logic               issue_write;
    ooo_pkg::rs_entry_t issue_entry;
    logic               rs_full;
    logic               alloc;
    logic [4:0]         alloc_rd;
    logic [`TAG_W-1:0]  alloc_tag;
    logic               rob_full;
    ooo_pkg::dispatch_t dispatch0;
    ooo_pkg::dispatch_t dispatch1;
    ooo_pkg::cdb_t      cdb0;
    ooo_pkg::cdb_t      cdb1;

    issue_unit issue_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .issue_write (issue_write),
        .issue_entry (issue_entry),
        .rs_full     (rs_full),
        .alloc       (alloc),
        .alloc_rd    (alloc_rd),
        .alloc_tag   (alloc_tag),
        .rob_full    (rob_full),
        .cdb0        (cdb0),
        .cdb1        (cdb1)
    );

    reservation_station reservation_station_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_write (issue_write),
        .issue_entry (issue_entry),
        .full        (rs_full),
        .cdb0        (cdb0),
        .cdb1        (cdb1),
        .dispatch0   (dispatch0),
        .dispatch1   (dispatch1)
    );

    exec_alu alu0_inst (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch0),
        .result   (cdb0)
    );

    exec_alu alu1_inst (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch1),
        .result   (cdb1)
    );

    reorder_buffer reorder_buffer_inst (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .alloc_rd  (alloc_rd),
        .alloc_tag (alloc_tag),
        .rob_full  (rob_full),
        .cdb0      (cdb0),
        .cdb1      (cdb1),
        .commit    (commit)
    );

endmodule

// ==== sim/tomasulo_core_checker.sv ====
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module tomasulo_core_checker (
    input logic                        clk,
    input logic                        rst,
    input logic                        issue_write,
    input logic                        full,
    input ooo_pkg::dispatch_t          dispatch0,
    input ooo_pkg::dispatch_t          dispatch1,
    input logic                        commit_valid,
    input logic [$clog2(`ROB_DEPTH):0] rob_count
);

    write_when_full: assert property (@(posedge clk) disable iff (!rst)
        issue_write |-> !full)
        else $error("Reservation station written while full");

    // The second port only fills after the first one has found an entry.
    dispatch_order: assert property (@(posedge clk) disable iff (!rst)
        dispatch1.valid |-> dispatch0.valid)
        else $error("dispatch1 valid without dispatch0");

    dispatch_tags: assert property (@(posedge clk) disable iff (!rst)
        (dispatch0.valid && dispatch1.valid) |-> dispatch0.dest != dispatch1.dest)
        else $error("Both dispatch ports carry the same tag");

    // Commit is registered, so the count one edge earlier is the one that matters.
    commit_when_empty: assert property (@(posedge clk) disable iff (!rst)
        commit_valid |-> $past(rob_count) != '0)
        else $error("Commit from an empty reorder buffer");

endmodule

bind reservation_station tomasulo_core_checker rs_checker_inst (
    .clk          (clk),
    .rst          (rst),
    .issue_write  (issue_write),
    .full         (full),
    .dispatch0    (dispatch0),
    .dispatch1    (dispatch1),
    .commit_valid (1'b0),
    .rob_count    ('0)
);

bind reorder_buffer tomasulo_core_checker rob_checker_inst (
    .clk          (clk),
    .rst          (rst),
    .issue_write  (1'b0),
    .full         (1'b0),
    .dispatch0    ('0),
    .dispatch1    ('0),
    .commit_valid (commit.valid),
    .rob_count    (count)
);

// ==== sim/tomasulo_core_tb.sv ====
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module tomasulo_core_tb;

    localparam int NUM_ROWS       = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + RESET_CYCLES;

    typedef struct packed {
        isa_pkg::instr_u    instr;
        logic [4:0]         rd;
        logic [`DATA_W-1:0] value;
    } row_t;

    logic             clk;
    logic             rst;
    logic             instr_valid;
    isa_pkg::instr_u  instr;
    logic             instr_ready;
    ooo_pkg::commit_t commit;

    row_t   rows [NUM_ROWS];
    int     row_count;
    int     commit_idx;
    int     errors;
    int     stalls;
    int     cycles;
    integer seed;

    tomasulo_core tomasulo_core_inst (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .commit      (commit)
    );

    always #50 clk = ~clk;  // 100 ns period.

    function automatic isa_pkg::instr_u r_instr(input isa_pkg::funct_e funct,
                                                input logic [4:0] rd,
                                                input logic [4:0] rs,
                                                input logic [4:0] rt);
        isa_pkg::instr_u w;
        w.r.opcode = isa_pkg::OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = 5'd0;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic isa_pkg::instr_u i_instr(input isa_pkg::opcode_e opcode,
                                                input logic [4:0] rt,
                                                input logic [4:0] rs,
                                                input logic [15:0] imm);
        isa_pkg::instr_u w;
        w.i.opcode = opcode;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    task automatic add_row(input isa_pkg::instr_u word, input logic [4:0] rd,
                           input logic [`DATA_W-1:0] value);
        rows[row_count] = '{instr: word, rd: rd, value: value};
        row_count++;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Results follow sequential execution with every register starting at zero.
    task automatic load_rows();
        add_row(i_instr(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5), 5'd1, 32'h0000_0005);
        add_row(i_instr(isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'hfffd), 5'd2, 32'hffff_fffd);
        add_row(i_instr(isa_pkg::OP_ORI, 5'd3, 5'd0, 16'h00f0), 5'd3, 32'h0000_00f0);
        add_row(i_instr(isa_pkg::OP_ANDI, 5'd4, 5'd3, 16'h0030), 5'd4, 32'h0000_0030);
        add_row(i_instr(isa_pkg::OP_XORI, 5'd5, 5'd1, 16'h000f), 5'd5, 32'h0000_000a);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd6, 5'd1, 5'd2), 5'd6, 32'h0000_0002);
        add_row(r_instr(isa_pkg::FN_SUB, 5'd7, 5'd1, 5'd2), 5'd7, 32'h0000_0008);
        add_row(r_instr(isa_pkg::FN_AND, 5'd8, 5'd3, 5'd4), 5'd8, 32'h0000_0030);
        add_row(r_instr(isa_pkg::FN_OR, 5'd9, 5'd1, 5'd5), 5'd9, 32'h0000_000f);
        add_row(r_instr(isa_pkg::FN_XOR, 5'd10, 5'd3, 5'd5), 5'd10, 32'h0000_00fa);
        add_row(r_instr(isa_pkg::FN_SLT, 5'd11, 5'd2, 5'd1), 5'd11, 32'h0000_0001);
        add_row(r_instr(isa_pkg::FN_SLT, 5'd12, 5'd1, 5'd2), 5'd12, 32'h0000_0000);
        add_row(i_instr(isa_pkg::OP_SLTI, 5'd13, 5'd2, 16'hfffe), 5'd13, 32'h0000_0001);
        add_row(i_instr(isa_pkg::OP_SLTI, 5'd14, 5'd2, 16'hfffd), 5'd14, 32'h0000_0000);
        add_row(r_instr(isa_pkg::FN_SLL, 5'd15, 5'd1, 5'd6), 5'd15, 32'h0000_0014);
        add_row(r_instr(isa_pkg::FN_SRL, 5'd16, 5'd2, 5'd6), 5'd16, 32'h3fff_ffff);
        add_row(i_instr(isa_pkg::OP_ADDI, 5'd17, 5'd0, 16'd33), 5'd17, 32'h0000_0021);
        // A shift amount of 33 uses only its low five bits.
        add_row(r_instr(isa_pkg::FN_SLL, 5'd18, 5'd1, 5'd17), 5'd18, 32'h0000_000a);
        add_row(r_instr(isa_pkg::FN_SRL, 5'd19, 5'd2, 5'd17), 5'd19, 32'h7fff_fffe);
        add_row(i_instr(isa_pkg::OP_ADDI, 5'd0, 5'd1, 16'd100), 5'd0, 32'h0000_0069);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd20, 5'd0, 5'd1), 5'd20, 32'h0000_0005);
        // Doubling chain, each link waits on the one before it.
        add_row(i_instr(isa_pkg::OP_ADDI, 5'd21, 5'd0, 16'd1), 5'd21, 32'h0000_0001);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd21, 5'd21, 5'd21), 5'd21, 32'h0000_0002);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd21, 5'd21, 5'd21), 5'd21, 32'h0000_0004);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd21, 5'd21, 5'd21), 5'd21, 32'h0000_0008);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd21, 5'd21, 5'd21), 5'd21, 32'h0000_0010);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd21, 5'd21, 5'd21), 5'd21, 32'h0000_0020);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd21, 5'd21, 5'd21), 5'd21, 32'h0000_0040);
        add_row(i_instr(isa_pkg::OP_ADDI, 5'd22, 5'd21, 16'hffff), 5'd22, 32'h0000_003f);
        add_row(r_instr(isa_pkg::FN_SUB, 5'd23, 5'd22, 5'd21), 5'd23, 32'hffff_ffff);
        add_row(r_instr(isa_pkg::FN_SLT, 5'd24, 5'd23, 5'd0), 5'd24, 32'h0000_0001);
        add_row(r_instr(isa_pkg::FN_SRL, 5'd25, 5'd23, 5'd17), 5'd25, 32'h7fff_ffff);
        add_row(r_instr(isa_pkg::FN_SLL, 5'd26, 5'd23, 5'd21), 5'd26, 32'hffff_ffff);
        add_row(r_instr(isa_pkg::FN_XOR, 5'd27, 5'd23, 5'd22), 5'd27, 32'hffff_ffc0);
        add_row(i_instr(isa_pkg::OP_SLTI, 5'd28, 5'd27, 16'h0000), 5'd28, 32'h0000_0001);
        add_row(i_instr(isa_pkg::OP_ADDI, 5'd29, 5'd23, 16'd1), 5'd29, 32'h0000_0000);
        add_row(i_instr(isa_pkg::OP_ORI, 5'd30, 5'd29, 16'h8000), 5'd30, 32'hffff_8000);
        add_row(i_instr(isa_pkg::OP_ANDI, 5'd31, 5'd30, 16'h7fff), 5'd31, 32'h0000_0000);
        add_row(r_instr(isa_pkg::FN_ADD, 5'd1, 5'd30, 5'd7), 5'd1, 32'hffff_8008);
        add_row(r_instr(isa_pkg::FN_SUB, 5'd2, 5'd1, 5'd1), 5'd2, 32'h0000_0000);
    endtask

    // Commits are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (rst && commit.valid) begin
            if (commit_idx < row_count) begin
                check_value($sformatf("rd of commit %0d", commit_idx), 32'(commit.rd),
                            32'(rows[commit_idx].rd));
                check_value($sformatf("value of commit %0d", commit_idx), commit.value,
                            rows[commit_idx].value);
            end else begin
                errors++;
                $display("Extra commit to r%0d at %0d ns after the whole program committed",
                         commit.rd, $time);
            end
            commit_idx++;
        end
        if (rst && instr_valid && !instr_ready) begin
            stalls++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions committed",
                     cycles, commit_idx, row_count);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int gap;
        seed        = 13;
        clk         = 1'b0;
        rst         = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        row_count   = 0;
        commit_idx  = 0;
        errors      = 0;
        stalls      = 0;
        cycles      = 0;
        load_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        check_value("commit valid after reset", 32'(commit.valid), 32'd0);
        check_value("instr_ready after reset", 32'(instr_ready), 32'd1);
        for (int i = 0; i < row_count; i++) begin
            gap = $random(seed) & 7;
            @(posedge clk);
            #1;
            if (gap == 0) begin
                instr_valid = 1'b0;  // Occasional idle cycle on the issue port.
                @(posedge clk);
                #1;
            end
            instr_valid = 1'b1;
            instr       = rows[i].instr;
            @(negedge clk);
            while (!instr_ready) begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
        wait (commit_idx >= row_count);
        repeat (10) @(posedge clk);
        check_value("number of commits", 32'(commit_idx), 32'(row_count));
        check_value("issue stall seen", 32'(stalls != 0), 32'd1);
        $display("Summary: %0d errors, %0d of %0d commits, %0d stall cycles",
                 errors, commit_idx, row_count, stalls);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/ooo_pkg.sv
rtl/issue_unit.sv
rtl/reservation_station.sv
rtl/exec_alu.sv
rtl/reorder_buffer.sv
rtl/tomasulo_core.sv
sim/tomasulo_core_checker.sv
sim/tomasulo_core_tb.sv
